//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // raw field widths
    localparam int WORD_W = 32;
    localparam int REG_W  = 5;
    localparam int IMM_W  = 16;

    // data word, also the pc
    typedef logic [WORD_W-1:0] word_t;
    // register number
    typedef logic [REG_W-1:0] reg_addr_t;
    // immediate as decoded
    typedef logic [IMM_W-1:0] imm_t;

    // entry layout, built up from bit 0
    // three single bit control flags at the bottom
    localparam int MULDIV_BIT   = 0;
    localparam int BRANCH_BIT   = 1;
    localparam int REGWRITE_BIT = 2;

    // immediate sits right above the flags
    localparam int IMM_LSB  = REGWRITE_BIT + 1;
    // second source, then first source
    localparam int RA2_LSB  = IMM_LSB + IMM_W;
    localparam int RA1_LSB  = RA2_LSB + REG_W;
    // destination register
    localparam int RDST_LSB = RA1_LSB + REG_W;
    // pc occupies the top word
    localparam int PC_LSB   = RDST_LSB + REG_W;

    // 66 bits in total
    localparam int ENTRY_W  = PC_LSB + WORD_W;

    // one queue entry, pc in the msbs
    typedef logic [ENTRY_W-1:0] entry_t;

endpackage

`default_nettype wire

//--- verilog/issue_pkg.sv
`default_nettype none

package issue_pkg;

    // entries held by each of the two banks
    localparam int QUEUE_DEPTH = 16;

    // pointer width for one bank
    localparam int QIDX_W = $clog2(QUEUE_DEPTH);

    // head and tail pointers, wrap modulo the depth
    typedef logic [QIDX_W-1:0] qidx_t;

    // decode and issue width, slot 0 is the older one
    localparam int ISSUE_SLOTS = 2;

endpackage

`default_nettype wire

//--- verilog/issue_bank.sv
`timescale 1ns/1ps
`default_nettype none

module issue_bank
    import isa_pkg::*, issue_pkg::*;
(
    input  wire logic   clk,
    // write side, fed from decode
    input  wire logic   we,
    input  wire qidx_t  waddr,
    input  wire logic   wsel,
    input  wire entry_t wdata [ISSUE_SLOTS],
    // read side, addressed by the head
    input  wire qidx_t  raddr,
    output entry_t      rdata
);

    // entry storage
    entry_t mem [QUEUE_DEPTH];

    // one write per cycle into this bank
    // wsel picks which decode slot lands here
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata[wsel];
        end
    end

    // head entry, no read latency
    // a write shows up here in the cycle after its edge
    assign rdata = mem[raddr];

    // tail pointer must be resolved whenever decode writes this bank
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else begin
        $error("issue_bank write with unknown address");
    end

endmodule

`default_nettype wire

//--- verilog/issue_pointers.sv
`timescale 1ns/1ps
`default_nettype none

module issue_pointers
    import issue_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic dec_valid [ISSUE_SLOTS],
    input  wire logic stall,
    input  wire logic stall_dec,
    input  wire logic flush,
    input  wire logic issue_en [ISSUE_SLOTS],
    output qidx_t     head_even,
    output qidx_t     head_odd,
    output qidx_t     tail_even,
    output qidx_t     tail_odd,
    output logic      we_even,
    output logic      we_odd,
    output logic      wsel_even,
    output logic      wsel_odd,
    output logic      odd_first,
    output logic      empty_even,
    output logic      empty_odd,
    output logic      overflow
);

    logic tails_eq;
    logic advance;
    logic pop_even;
    logic pop_odd;

    // pointers count down and wrap
    function automatic qidx_t step(input qidx_t p);
        return p - qidx_t'(1);
    endfunction

    // equal tails mean the odd bank takes the older entry
    assign tails_eq = (tail_odd == tail_even);

    // equal heads mean the oldest entry sits in the odd bank
    assign odd_first = (head_odd == head_even);

    // write routing, keeps program order across the banks
    assign we_odd    = !stall && (tails_eq ? dec_valid[0] : dec_valid[1]);
    assign we_even   = !stall && (tails_eq ? dec_valid[1] : dec_valid[0]);
    assign wsel_odd  = !tails_eq;
    assign wsel_even = tails_eq;

    assign empty_even = (head_even == tail_even);
    assign empty_odd  = (head_odd == tail_odd);

    // 15 entries in either bank, one more write would look empty
    assign overflow = (step(tail_even) == head_even) || (step(tail_odd) == head_odd);

    // drain keeps issuing while decode is free even if issue is stalled
    assign advance = !stall || (overflow && !stall_dec);

    // map slot enables back onto banks
    assign pop_odd  = odd_first ? issue_en[0] : issue_en[1];
    assign pop_even = odd_first ? issue_en[1] : issue_en[0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else if (flush) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else begin
            if (we_even) begin
                tail_even <= step(tail_even);
            end
            if (we_odd) begin
                tail_odd <= step(tail_odd);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (flush) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (advance) begin
            if (pop_even) begin
                head_even <= step(head_even);
            end
            if (pop_odd) begin
                head_odd <= step(head_odd);
            end
        end
    end

    // upstream has to hold decode once a bank is at its limit
    a_no_write_on_overflow: assert property (
        @(posedge clk) disable iff (!arst_n || flush)
        (overflow && !stall) |-> !(we_even || we_odd)
    ) else begin
        $error("issue queue written while overflow was high");
    end

    // older bank empty means the younger one is empty too
    a_older_bank_first: assert property (
        @(posedge clk) disable iff (!arst_n)
        (odd_first ? empty_odd : empty_even) |-> (empty_even && empty_odd)
    ) else begin
        $error("younger bank holds entries behind an empty older bank");
    end

endmodule

`default_nettype wire

//--- verilog/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select
    import isa_pkg::*, issue_pkg::*;
(
    input  wire entry_t rdata_even,
    input  wire entry_t rdata_odd,
    input  wire logic   odd_first,
    input  wire logic   empty_even,
    input  wire logic   empty_odd,
    input  wire logic   byp_ready1 [ISSUE_SLOTS],
    input  wire logic   byp_ready2 [ISSUE_SLOTS],
    output entry_t      cand [ISSUE_SLOTS],
    output logic        cand_valid [ISSUE_SLOTS],
    output logic        issue_en [ISSUE_SLOTS],
    output logic        first_branch
);

    logic      ready [ISSUE_SLOTS];
    reg_addr_t first_rdst;
    reg_addr_t second_ra1;
    reg_addr_t second_ra2;
    logic      raw_hazard;
    logic      muldiv_pair;
    logic      second_branch;

    // oldest entry first, the other bank head behind it
    always_comb begin
        cand_valid[0] = odd_first ? !empty_odd : !empty_even;
        cand_valid[1] = odd_first ? !empty_even : !empty_odd;
        cand[0] = '0;
        cand[1] = '0;
        // empty bank gives an all zero candidate
        if (cand_valid[0]) begin
            cand[0] = odd_first ? rdata_odd : rdata_even;
        end
        if (cand_valid[1]) begin
            cand[1] = odd_first ? rdata_even : rdata_odd;
        end
    end

    // both sources ready per slot
    always_comb begin
        for (int i = 0; i < ISSUE_SLOTS; i++) begin
            ready[i] = cand_valid[i] && byp_ready1[i] && byp_ready2[i];
        end
    end

    // fields used by the pairing rules
    assign first_rdst    = cand[0][RDST_LSB +: REG_W];
    assign second_ra1    = cand[1][RA1_LSB +: REG_W];
    assign second_ra2    = cand[1][RA2_LSB +: REG_W];
    assign first_branch  = cand[0][BRANCH_BIT];
    assign second_branch = cand[1][BRANCH_BIT];

    // younger reads what the older writes
    // a branch in front is exempt since its slot may read the old value
    assign raw_hazard = cand[0][REGWRITE_BIT] && !first_branch &&
                        ((first_rdst == second_ra1) || (first_rdst == second_ra2));

    // only one multiply/divide unit
    assign muldiv_pair = cand[0][MULDIV_BIT] && cand[1][MULDIV_BIT];

    // branch waits until its delay slot can go with it
    assign issue_en[0] = ready[0] && !(first_branch && !ready[1]);

    assign issue_en[1] = issue_en[0] && ready[1] && !second_branch &&
                         !muldiv_pair && !raw_hazard;

endmodule

`default_nettype wire

//--- verilog/issue_operands.sv
`timescale 1ns/1ps
`default_nettype none

module issue_operands
    import isa_pkg::*, issue_pkg::*;
(
    input  wire entry_t cand [ISSUE_SLOTS],
    input  wire logic   issue_en [ISSUE_SLOTS],
    input  wire logic   first_branch,
    input  wire word_t  rf_rd1 [ISSUE_SLOTS],
    input  wire word_t  rf_rd2 [ISSUE_SLOTS],
    input  wire word_t  byp_data1 [ISSUE_SLOTS],
    input  wire word_t  byp_data2 [ISSUE_SLOTS],
    input  wire logic   byp_hit1 [ISSUE_SLOTS],
    input  wire logic   byp_hit2 [ISSUE_SLOTS],
    output logic        iss_valid [ISSUE_SLOTS],
    output entry_t      iss_entry [ISSUE_SLOTS],
    output word_t       iss_op1 [ISSUE_SLOTS],
    output word_t       iss_op2 [ISSUE_SLOTS],
    output logic        iss_slot
);

    // per slot output gating and operand mux
    always_comb begin
        for (int i = 0; i < ISSUE_SLOTS; i++) begin
            iss_valid[i] = issue_en[i];
            // idle slot drives zeros
            iss_entry[i] = '0;
            iss_op1[i]   = '0;
            iss_op2[i]   = '0;
            if (issue_en[i]) begin
                iss_entry[i] = cand[i];
                // forwarded value wins over the register file
                iss_op1[i] = byp_hit1[i] ? byp_data1[i] : rf_rd1[i];
                iss_op2[i] = byp_hit2[i] ? byp_data2[i] : rf_rd2[i];
            end
        end
    end

    // younger issue behind a branch is its delay slot
    assign iss_slot = issue_en[1] && first_branch;

endmodule

`default_nettype wire

//--- verilog/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import isa_pkg::*, issue_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    // decoded pair, slot 0 older
    input  wire logic   dec_valid [ISSUE_SLOTS],
    input  wire entry_t dec_entry [ISSUE_SLOTS],
    input  wire logic   stall,
    input  wire logic   stall_dec,
    input  wire logic   flush,
    // register file read ports
    output reg_addr_t   rf_ra1 [ISSUE_SLOTS],
    output reg_addr_t   rf_ra2 [ISSUE_SLOTS],
    input  wire word_t  rf_rd1 [ISSUE_SLOTS],
    input  wire word_t  rf_rd2 [ISSUE_SLOTS],
    // bypass network
    input  wire logic   byp_ready1 [ISSUE_SLOTS],
    input  wire logic   byp_ready2 [ISSUE_SLOTS],
    input  wire logic   byp_hit1 [ISSUE_SLOTS],
    input  wire logic   byp_hit2 [ISSUE_SLOTS],
    input  wire word_t  byp_data1 [ISSUE_SLOTS],
    input  wire word_t  byp_data2 [ISSUE_SLOTS],
    // issued pair
    output logic        iss_valid [ISSUE_SLOTS],
    output entry_t      iss_entry [ISSUE_SLOTS],
    output word_t       iss_op1 [ISSUE_SLOTS],
    output word_t       iss_op2 [ISSUE_SLOTS],
    output logic        iss_slot,
    output logic        overflow
);

    qidx_t  head_even;
    qidx_t  head_odd;
    qidx_t  tail_even;
    qidx_t  tail_odd;
    logic   we_even;
    logic   we_odd;
    logic   wsel_even;
    logic   wsel_odd;
    logic   odd_first;
    logic   empty_even;
    logic   empty_odd;
    entry_t rdata_even;
    entry_t rdata_odd;
    entry_t cand [ISSUE_SLOTS];
    logic   issue_en [ISSUE_SLOTS];
    logic   first_branch;

    // even bank
    issue_bank bank_even_inst (
        .clk   (clk),
        .we    (we_even),
        .waddr (tail_even),
        .wsel  (wsel_even),
        .wdata (dec_entry),
        .raddr (head_even),
        .rdata (rdata_even)
    );

    // odd bank
    issue_bank bank_odd_inst (
        .clk   (clk),
        .we    (we_odd),
        .waddr (tail_odd),
        .wsel  (wsel_odd),
        .wdata (dec_entry),
        .raddr (head_odd),
        .rdata (rdata_odd)
    );

    issue_pointers pointers_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .dec_valid  (dec_valid),
        .stall      (stall),
        .stall_dec  (stall_dec),
        .flush      (flush),
        .issue_en   (issue_en),
        .head_even  (head_even),
        .head_odd   (head_odd),
        .tail_even  (tail_even),
        .tail_odd   (tail_odd),
        .we_even    (we_even),
        .we_odd     (we_odd),
        .wsel_even  (wsel_even),
        .wsel_odd   (wsel_odd),
        .odd_first  (odd_first),
        .empty_even (empty_even),
        .empty_odd  (empty_odd),
        .overflow   (overflow)
    );

    // candidate valids stay local to select
    issue_select select_inst (
        .rdata_even   (rdata_even),
        .rdata_odd    (rdata_odd),
        .odd_first    (odd_first),
        .empty_even   (empty_even),
        .empty_odd    (empty_odd),
        .byp_ready1   (byp_ready1),
        .byp_ready2   (byp_ready2),
        .cand         (cand),
        .cand_valid   (),
        .issue_en     (issue_en),
        .first_branch (first_branch)
    );

    issue_operands operands_inst (
        .cand         (cand),
        .issue_en     (issue_en),
        .first_branch (first_branch),
        .rf_rd1       (rf_rd1),
        .rf_rd2       (rf_rd2),
        .byp_data1    (byp_data1),
        .byp_data2    (byp_data2),
        .byp_hit1     (byp_hit1),
        .byp_hit2     (byp_hit2),
        .iss_valid    (iss_valid),
        .iss_entry    (iss_entry),
        .iss_op1      (iss_op1),
        .iss_op2      (iss_op2),
        .iss_slot     (iss_slot)
    );

    // source numbers of both candidates go out to the register file
    for (genvar i = 0; i < ISSUE_SLOTS; i++) begin : g_rf_ra
        assign rf_ra1[i] = cand[i][RA1_LSB +: REG_W];
        assign rf_ra2[i] = cand[i][RA2_LSB +: REG_W];
    end

endmodule

`default_nettype wire

//--- dv/issue_stage_checks.svh
`ifndef ISSUE_STAGE_CHECKS_SVH
`define ISSUE_STAGE_CHECKS_SVH

// queue entry compare
task automatic check_entry(input string name, input entry_t got, input entry_t exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
        abort_run("issue stage entry mismatch");
    end
endtask

// operand value compare
task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s is %h, expected %h", $time, name, got, exp);
        abort_run("issue stage operand mismatch");
    end
endtask

// register number compare
task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s is %0d, expected %0d", $time, name, got, exp);
        abort_run("issue stage register number mismatch");
    end
endtask

// single flag compare
task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Error: time %0t, %s is %b, expected %b", $time, name, got, exp);
        abort_run("issue stage flag mismatch");
    end
endtask

// lcg step, numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// next random operand value
function automatic word_t next_operand();
    lcg_state = lcg_next(lcg_state);
    return lcg_state;
endfunction

`endif

//--- dv/issue_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage_tb
    import isa_pkg::*, issue_pkg::*;
();

    localparam int ROWS = 11;
    // single writes that bring the odd bank to 15 entries
    localparam int FILL = 29;

    // one stimulus row, ready and hit bits as {r2[1], r1[1], r2[0], r1[0]}
    typedef struct packed {
        entry_t     e0;
        entry_t     e1;
        logic [1:0] dv;
        logic [3:0] rdy;
        logic [3:0] hit;
        logic [1:0] exp_v;
        logic       exp_slot;
    } row_t;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      dec_valid [ISSUE_SLOTS];
    entry_t    dec_entry [ISSUE_SLOTS];
    logic      stall;
    logic      stall_dec;
    logic      flush;
    reg_addr_t rf_ra1 [ISSUE_SLOTS];
    reg_addr_t rf_ra2 [ISSUE_SLOTS];
    word_t     rf_rd1 [ISSUE_SLOTS];
    word_t     rf_rd2 [ISSUE_SLOTS];
    logic      byp_ready1 [ISSUE_SLOTS];
    logic      byp_ready2 [ISSUE_SLOTS];
    logic      byp_hit1 [ISSUE_SLOTS];
    logic      byp_hit2 [ISSUE_SLOTS];
    word_t     byp_data1 [ISSUE_SLOTS];
    word_t     byp_data2 [ISSUE_SLOTS];
    logic      iss_valid [ISSUE_SLOTS];
    entry_t    iss_entry [ISSUE_SLOTS];
    word_t     iss_op1 [ISSUE_SLOTS];
    word_t     iss_op2 [ISSUE_SLOTS];
    logic      iss_slot;
    logic      overflow;

    logic [31:0] lcg_state;
    row_t        rows [ROWS];
    entry_t      ea;
    entry_t      eb;
    entry_t      ed;
    entry_t      em0;
    entry_t      em1;
    entry_t      ebr;
    entry_t      ebr2;
    entry_t      edly;

    issue_stage issue_stage_inst (.*);

    // 8 ns period
    always #4 clk = ~clk;

    `include "issue_stage_checks.svh"

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    // flags as {regwrite, branch, muldiv}
    function automatic entry_t make_entry(input word_t pc, input reg_addr_t rdst,
                                          input reg_addr_t ra1, input reg_addr_t ra2,
                                          input imm_t imm, input logic [2:0] flags);
        entry_t e;
        e = '0;
        e[PC_LSB +: WORD_W]  = pc;
        e[RDST_LSB +: REG_W] = rdst;
        e[RA1_LSB +: REG_W]  = ra1;
        e[RA2_LSB +: REG_W]  = ra2;
        e[IMM_LSB +: IMM_W]  = imm;
        e[REGWRITE_BIT]      = flags[2];
        e[BRANCH_BIT]        = flags[1];
        e[MULDIV_BIT]        = flags[0];
        return e;
    endfunction

    // independent entries used to fill the queue
    function automatic entry_t fill_entry(input int n);
        return make_entry(32'h2000 + 32'(n * 4), 5'(n), 5'd0, 5'd0, 16'(n), 3'b000);
    endfunction

    task automatic build_table();
        ea   = make_entry(32'h100, 5'd3, 5'd1, 5'd2, 16'h0011, 3'b100);
        eb   = make_entry(32'h104, 5'd6, 5'd4, 5'd5, 16'h0022, 3'b100);
        ed   = make_entry(32'h104, 5'd7, 5'd3, 5'd5, 16'h0033, 3'b100);
        em0  = make_entry(32'h100, 5'd0, 5'd8, 5'd9, 16'h0000, 3'b001);
        em1  = make_entry(32'h104, 5'd0, 5'd10, 5'd11, 16'h0000, 3'b001);
        // branch and link, writes r31
        ebr  = make_entry(32'h100, 5'd31, 5'd1, 5'd2, 16'h0040, 3'b110);
        ebr2 = make_entry(32'h104, 5'd0, 5'd4, 5'd5, 16'h0080, 3'b010);
        // delay slot reading the link register
        edly = make_entry(32'h104, 5'd5, 5'd31, 5'd2, 16'h0044, 3'b100);
        // independent pair
        rows[0]  = '{ea, eb, 2'b11, 4'hf, 4'h0, 2'b11, 1'b0};
        // raw on r3, two muldiv, branch in slot 1
        rows[1]  = '{ea, ed, 2'b11, 4'hf, 4'h0, 2'b01, 1'b0};
        rows[2]  = '{em0, em1, 2'b11, 4'hf, 4'h0, 2'b01, 1'b0};
        rows[3]  = '{ea, ebr2, 2'b11, 4'hf, 4'h0, 2'b01, 1'b0};
        // branch first, raw exempt, delay slot marked
        rows[4]  = '{ebr, edly, 2'b11, 4'hf, 4'h0, 2'b11, 1'b1};
        // operand source patterns
        rows[5]  = '{ea, eb, 2'b11, 4'hf, 4'hf, 2'b11, 1'b0};
        rows[6]  = '{ea, eb, 2'b11, 4'hf, 4'h5, 2'b11, 1'b0};
        rows[7]  = '{ea, eb, 2'b11, 4'hf, 4'ha, 2'b11, 1'b0};
        // lone instruction in slot 0
        rows[8]  = '{ea, eb, 2'b01, 4'hf, 4'h3, 2'b01, 1'b0};
        // older not ready holds both
        rows[9]  = '{ea, eb, 2'b11, 4'he, 4'h0, 2'b00, 1'b0};
        // branch waits for its partner, must stay last
        rows[10] = '{ebr, edly, 2'b11, 4'h3, 4'h0, 2'b00, 1'b0};
    endtask

    // ready and hit levels plus fresh operand values
    task automatic drive_bypass(input logic [3:0] rdy, input logic [3:0] hit);
        for (int i = 0; i < ISSUE_SLOTS; i++) begin
            byp_ready1[i] <= rdy[2*i];
            byp_ready2[i] <= rdy[2*i+1];
            byp_hit1[i]   <= hit[2*i];
            byp_hit2[i]   <= hit[2*i+1];
            rf_rd1[i]     <= next_operand();
            rf_rd2[i]     <= next_operand();
            byp_data1[i]  <= next_operand();
            byp_data2[i]  <= next_operand();
        end
    endtask

    // decode pair valid for exactly one edge
    task automatic write_pair(input entry_t e0, input entry_t e1, input logic [1:0] dv,
                              input logic [3:0] rdy, input logic [3:0] hit);
        @(posedge clk);
        dec_entry[0] <= e0;
        dec_entry[1] <= e1;
        dec_valid[0] <= dv[0];
        dec_valid[1] <= dv[1];
        drive_bypass(rdy, hit);
        @(posedge clk);
        dec_valid[0] <= 1'b0;
        dec_valid[1] <= 1'b0;
    endtask

    task automatic flush_queue();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // alternate banks until the odd one holds 15 entries
    task automatic fill_queue();
        for (int n = 0; n < FILL; n++) begin
            @(negedge clk);
            check_bit("overflow", overflow, 1'b0);
            write_pair(fill_entry(n), '0, 2'b01, 4'h0, 4'h0);
        end
        @(negedge clk);
        check_bit("overflow", overflow, 1'b1);
    endtask

    task automatic check_idle();
        @(negedge clk);
        check_bit("iss_valid[0]", iss_valid[0], 1'b0);
        check_bit("iss_valid[1]", iss_valid[1], 1'b0);
        check_bit("iss_slot", iss_slot, 1'b0);
        check_bit("overflow", overflow, 1'b0);
    endtask

    // idle slots must read back as zero
    task automatic check_issue(input logic [1:0] exp_v, input logic exp_slot,
                               input logic [1:0] dv, input logic [3:0] hit,
                               input entry_t e0, input entry_t e1);
        entry_t    exp_e;
        word_t     exp_op1;
        word_t     exp_op2;
        reg_addr_t exp_ra1;
        reg_addr_t exp_ra2;
        @(negedge clk);
        for (int i = 0; i < ISSUE_SLOTS; i++) begin
            exp_e = (i == 0) ? e0 : e1;
            // read ports follow the candidates, issued or not
            exp_ra1 = dv[i] ? exp_e[RA1_LSB +: REG_W] : '0;
            exp_ra2 = dv[i] ? exp_e[RA2_LSB +: REG_W] : '0;
            // operand source from the table hit bits
            exp_op1 = rf_rd1[i];
            exp_op2 = rf_rd2[i];
            if (hit[2*i]) begin
                exp_op1 = byp_data1[i];
            end
            if (hit[2*i+1]) begin
                exp_op2 = byp_data2[i];
            end
            if (!exp_v[i]) begin
                exp_e   = '0;
                exp_op1 = '0;
                exp_op2 = '0;
            end
            check_bit($sformatf("iss_valid[%0d]", i), iss_valid[i], exp_v[i]);
            check_entry($sformatf("iss_entry[%0d]", i), iss_entry[i], exp_e);
            check_word($sformatf("iss_op1[%0d]", i), iss_op1[i], exp_op1);
            check_word($sformatf("iss_op2[%0d]", i), iss_op2[i], exp_op2);
            check_reg($sformatf("rf_ra1[%0d]", i), rf_ra1[i], exp_ra1);
            check_reg($sformatf("rf_ra2[%0d]", i), rf_ra2[i], exp_ra2);
        end
        check_bit("iss_slot", iss_slot, exp_slot);
        check_bit("overflow", overflow, 1'b0);
    endtask

    initial begin
        int issued;
        int cycles;
        arst_n    = 1'b0;
        stall     = 1'b0;
        stall_dec = 1'b0;
        flush     = 1'b0;
        lcg_state = 32'h748f;
        for (int i = 0; i < ISSUE_SLOTS; i++) begin
            dec_valid[i]  = 1'b0;
            dec_entry[i]  = '0;
            rf_rd1[i]     = '0;
            rf_rd2[i]     = '0;
            byp_ready1[i] = 1'b0;
            byp_ready2[i] = 1'b0;
            byp_hit1[i]   = 1'b0;
            byp_hit2[i]   = 1'b0;
            byp_data1[i]  = '0;
            byp_data2[i]  = '0;
        end
        build_table();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        check_idle();

        // pairing and operand rows, each from an empty queue
        for (int r = 0; r < ROWS; r++) begin
            flush_queue();
            check_idle();
            write_pair(rows[r].e0, rows[r].e1, rows[r].dv, rows[r].rdy, rows[r].hit);
            check_issue(rows[r].exp_v, rows[r].exp_slot, rows[r].dv, rows[r].hit,
                        rows[r].e0, rows[r].e1);
        end

        // partner of the waiting branch becomes ready
        @(posedge clk);
        drive_bypass(4'hf, 4'h0);
        check_issue(2'b11, 1'b1, 2'b11, 4'h0, ebr, edly);

        fill_queue();

        // drain in write order
        @(posedge clk);
        drive_bypass(4'hf, 4'h0);
        issued = 0;
        cycles = 0;
        while (issued < FILL) begin
            @(negedge clk);
            for (int i = 0; i < ISSUE_SLOTS; i++) begin
                if (iss_valid[i]) begin
                    check_entry($sformatf("iss_entry[%0d]", i), iss_entry[i],
                                fill_entry(issued));
                    issued++;
                end
            end
            cycles++;
            if (cycles > 2 * FILL) begin
                abort_run("queue did not drain after overflow");
            end
        end
        check_idle();

        // flush of a full queue, with ready levels up any survivor would issue
        fill_queue();
        flush_queue();
        drive_bypass(4'hf, 4'h0);
        check_idle();

        // reset in the middle of traffic
        fill_queue();
        @(posedge clk);
        arst_n <= 1'b0;
        drive_bypass(4'hf, 4'h0);
        check_idle();
        @(posedge clk);
        arst_n <= 1'b1;
        check_idle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+dv
verilog/isa_pkg.sv
verilog/issue_pkg.sv
verilog/issue_bank.sv
verilog/issue_pointers.sv
verilog/issue_select.sv
verilog/issue_operands.sv
verilog/issue_stage.sv
dv/issue_stage_tb.sv

//--- run.sh
#!/usr/bin/env bash

# run from the project root so the paths in vlog.f resolve
cd "$(dirname "$0")" || exit 1

log=sim.log

# build the testbench with assertions enabled
if ! verilator --binary --timing --assert --top-module issue_stage_tb \
        -f vlog.f -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

# run and keep the transcript
./obj_dir/Vissue_stage_tb > "$log" 2>&1
run_status=$?
cat "$log"

# the log decides the result
if grep -q "STATUS: FAIL" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "STATUS: PASS" "$log"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
